//--- src/isaPkg.sv
// Fixed 16-bit ISA with eight registers; PCs count words and immediates are signed 6-bit only
package isaPkg;

	typedef logic [15:0] wordT;	// Data word, program counter or extended immediate
	typedef logic [2:0] regIdxT;
	typedef logic [5:0] imm6T;

	typedef enum logic [3:0] {
		OpNop  = 4'h0,
		OpAdd  = 4'h1,
		OpSub  = 4'h2,
		OpAnd  = 4'h3,
		OpXor  = 4'h4,
		OpAddi = 4'h5,
		OpSlt  = 4'h6,
		OpBeqz = 4'h7,
		OpHalt = 4'hf
	} opcodeT;

	typedef enum logic [1:0] {
		AluAdd = 2'd0,
		AluAnd = 2'd1,
		AluXor = 2'd2,
		AluSlt = 2'd3
	} aluOpT;

	////////////////////////////////////////////////////////////////////
	// Instruction word layout
	////////////////////////////////////////////////////////////////////

	// The tail holds the immediate; its upper three bits double as rt
	typedef struct packed {
		opcodeT opcode;	// Bits 15..12
		regIdxT rd;	// Bits 11..9
		regIdxT rs;	// Bits 8..6
		imm6T   tail;	// Bits 5..0
	} instrT;

endpackage

//--- src/pipePkg.sv
// Bundles between decode, execute and writeback; the field set matches the reduced ISA only
package pipePkg;

	////////////////////////////////////////////////////////////////////
	// Decode to execute
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic          valid;	// Low marks a bubble
		isaPkg::aluOpT aluOp;
		logic          invB;	// Invert the second operand before the adder
		logic          cin;
		logic          aluSrc;	// Second operand is the immediate
		logic          branch;
		logic          set;	// Result is the signed less-than flag
		logic          regWrEn;
		logic          rtValid;	// rt is really read
		logic          halt;
	} deCtrlT;

	typedef struct packed {
		deCtrlT         ctrl;
		isaPkg::wordT   op1;	// Value of rs
		isaPkg::wordT   op2;	// Value of rt
		isaPkg::wordT   imm;
		isaPkg::wordT   incPc;
		isaPkg::regIdxT rs;
		isaPkg::regIdxT rt;
		isaPkg::regIdxT writeReg;
	} deBundleT;

	////////////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////////////

	// A completed result on its way into the register file
	typedef struct packed {
		logic           valid;
		isaPkg::regIdxT regIdx;
		isaPkg::wordT   data;
	} wbT;

endpackage

//--- src/regFile.sv
// Eight 16-bit registers cleared by reset; a read of the register being written returns new data
module regFile (
	input  logic           clk,
	input  logic           rstN,
	input  isaPkg::regIdxT rdIdxA,
	input  isaPkg::regIdxT rdIdxB,
	output isaPkg::wordT   rdDataA,
	output isaPkg::wordT   rdDataB,
	input  pipePkg::wbT    wb
);

	isaPkg::wordT regs [8];
	logic hitA;
	logic hitB;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.regIdx] <= wb.data;
		end
	end

	// Same-cycle bypass lets decode see the result the writeback stage holds
	assign hitA = wb.valid && (wb.regIdx == rdIdxA);
	assign hitB = wb.valid && (wb.regIdx == rdIdxB);

	assign rdDataA = hitA ? wb.data : regs[rdIdxA];
	assign rdDataB = hitB ? wb.data : regs[rdIdxB];

endmodule

//--- src/instrDecoder.sv
// Combinational decode of one word; unknown opcodes become bubbles and operands come from regFile
module instrDecoder (
	input  isaPkg::wordT      instr,
	input  isaPkg::wordT      instrPc,
	input  logic              instrValid,
	output isaPkg::regIdxT    rdIdxA,
	output isaPkg::regIdxT    rdIdxB,
	input  isaPkg::wordT      rdDataA,
	input  isaPkg::wordT      rdDataB,
	output pipePkg::deBundleT decBundle
);

	isaPkg::instrT fields;
	pipePkg::deCtrlT ctrl;

	assign fields = isaPkg::instrT'(instr);
	assign rdIdxA = fields.rs;
	assign rdIdxB = fields.tail[5:3];	// rt

	always_comb begin
		ctrl = '0;
		ctrl.valid = instrValid;
		ctrl.aluOp = isaPkg::AluAdd;
		case (fields.opcode)
			isaPkg::OpNop, isaPkg::OpHalt: ctrl.halt = (fields.opcode == isaPkg::OpHalt);
			isaPkg::OpAdd: begin
				ctrl.regWrEn = 1'b1;
				ctrl.rtValid = 1'b1;
			end
			isaPkg::OpSub: begin
				ctrl.invB = 1'b1;	// rs + ~rt + 1
				ctrl.cin = 1'b1;
				ctrl.regWrEn = 1'b1;
				ctrl.rtValid = 1'b1;
			end
			isaPkg::OpAnd, isaPkg::OpXor: begin
				ctrl.aluOp = (fields.opcode == isaPkg::OpAnd) ? isaPkg::AluAnd : isaPkg::AluXor;
				ctrl.regWrEn = 1'b1;
				ctrl.rtValid = 1'b1;
			end
			isaPkg::OpAddi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrEn = 1'b1;
			end
			isaPkg::OpSlt: begin
				// The adder subtracts and the flag is taken from its sign
				ctrl.aluOp = isaPkg::AluSlt;
				ctrl.invB = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.set = 1'b1;
				ctrl.regWrEn = 1'b1;
				ctrl.rtValid = 1'b1;
			end
			isaPkg::OpBeqz: ctrl.branch = 1'b1;
			default: ctrl.valid = 1'b0;
		endcase
	end

	always_comb begin
		decBundle.ctrl = ctrl;
		decBundle.op1 = rdDataA;
		decBundle.op2 = rdDataB;
		decBundle.imm = {{10{fields.tail[5]}}, fields.tail};
		decBundle.incPc = instrPc + 16'd1;
		decBundle.rs = fields.rs;
		decBundle.rt = fields.tail[5:3];
		decBundle.writeReg = fields.rd;
	end

endmodule

//--- src/hazardCtrl.sv
// Stall and flush control with no forwarding; once halted only reset brings the slice back
module hazardCtrl (
	input  logic              clk,
	input  logic              rstN,
	input  pipePkg::deBundleT decBundle,
	input  pipePkg::deBundleT exBundle,
	input  logic              takenBranch,
	output logic              stall,
	output logic              flush,
	output logic              halted
);

	typedef enum logic {
		StRun,
		StHalted
	} stateT;

	stateT state;
	logic exWrites;
	logic haltInEx;
	logic rsRead;
	logic rsHit;
	logic rtHit;
	logic hazard;

	assign exWrites = exBundle.ctrl.valid & exBundle.ctrl.regWrEn;
	assign haltInEx = exBundle.ctrl.valid & exBundle.ctrl.halt;
	assign rsRead = decBundle.ctrl.regWrEn | decBundle.ctrl.branch;	// All but NOP and HALT
	assign rsHit = rsRead && (decBundle.rs == exBundle.writeReg);
	assign rtHit = decBundle.ctrl.rtValid && (decBundle.rt == exBundle.writeReg);
	assign hazard = decBundle.ctrl.valid & exWrites & (rsHit | rtHit);

	// The word behind a halt is dropped too, so nothing writes after it
	assign halted = (state == StHalted);
	assign flush = takenBranch | haltInEx | halted;
	assign stall = hazard & ~flush;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StRun;
		end else begin
			case (state)
				StRun: if (haltInEx) state <= StHalted;
				StHalted: state <= StHalted;
			endcase
		end
	end

	// Once halted the execute stage stays empty and nothing waits on it
	assert property (@(posedge clk) disable iff (!rstN) halted |-> !stall && !exBundle.ctrl.valid);

endmodule

//--- src/pipeDe.sv
// Decode to execute register; a stalled word stays with the fetch unit while a bubble moves on
module pipeDe (
	input  logic              clk,
	input  logic              rstN,
	input  logic              stall,
	input  logic              flush,
	input  pipePkg::deBundleT decBundle,
	output pipePkg::deBundleT exBundle
);

	////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exBundle <= '0;
		end else if (flush || stall) begin
			// A flush drops the word, a stall lets it wait at the decode input
			exBundle <= '0;
		end else begin
			exBundle <= decBundle;
		end
	end

	// The bubble clears the dependency, so a stall never lasts past one cycle
	assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall);

endmodule

//--- src/execUnit.sv
// ALU, BEQZ resolution and the writeback register; no flags are kept between instructions
module execUnit (
	input  logic              clk,
	input  logic              rstN,
	input  pipePkg::deBundleT exBundle,
	output logic              takenBranch,
	output isaPkg::wordT      branchTarget,
	output pipePkg::wbT       wbBus
);

	isaPkg::wordT opB;
	isaPkg::wordT opBMux;
	isaPkg::wordT sum;
	isaPkg::wordT aluOut;
	isaPkg::wordT result;
	logic lessThan;
	pipePkg::wbT wbNext;

	////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////

	assign opB = exBundle.ctrl.aluSrc ? exBundle.imm : exBundle.op2;
	assign opBMux = exBundle.ctrl.invB ? ~opB : opB;
	assign sum = exBundle.op1 + opBMux + {15'd0, exBundle.ctrl.cin};

	// Signs differ means the negative one is smaller, else the difference tells
	assign lessThan = (exBundle.op1[15] != opB[15]) ? exBundle.op1[15] : sum[15];

	always_comb begin
		unique case (exBundle.ctrl.aluOp)
			isaPkg::AluAdd, isaPkg::AluSlt: aluOut = sum;
			isaPkg::AluAnd:                 aluOut = exBundle.op1 & opB;
			isaPkg::AluXor:                 aluOut = exBundle.op1 ^ opB;
		endcase
	end

	assign result = exBundle.ctrl.set ? {15'd0, lessThan} : aluOut;

	// BEQZ tests rs and jumps relative to the next word
	assign takenBranch = exBundle.ctrl.valid & exBundle.ctrl.branch & (exBundle.op1 == '0);
	assign branchTarget = exBundle.incPc + exBundle.imm;

	////////////////////////////////////////////////////////////////////
	// Writeback
	////////////////////////////////////////////////////////////////////

	always_comb begin
		wbNext.valid = exBundle.ctrl.valid & exBundle.ctrl.regWrEn;
		wbNext.regIdx = exBundle.writeReg;
		wbNext.data = result;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbBus <= '0;
		end else begin
			wbBus <= wbNext;
		end
	end

	// The word fetched behind a taken branch never reaches execute
	assert property (@(posedge clk) disable iff (!rstN) takenBranch |=> !exBundle.ctrl.valid);

endmodule

//--- src/decodeExecCore.sv
// Decode to writeback slice; fetch must hold its word while stall is high and follow redirect
module decodeExecCore (
	input  logic           clk,
	input  logic           rstN,
	input  logic           instrValid,
	input  isaPkg::wordT   instr,
	input  isaPkg::wordT   instrPc,
	output logic           stall,
	output logic           redirect,
	output logic           wbValid,
	output logic           halted,
	output isaPkg::wordT   redirectPc,
	output isaPkg::wordT   wbData,
	output isaPkg::regIdxT wbReg
);

	isaPkg::regIdxT rdIdxA;
	isaPkg::regIdxT rdIdxB;
	isaPkg::wordT rdDataA;
	isaPkg::wordT rdDataB;
	isaPkg::wordT branchTarget;
	pipePkg::deBundleT decBundle;
	pipePkg::deBundleT exBundle;
	pipePkg::wbT wbBus;
	logic flush;
	logic takenBranch;

	regFile u_regFile (
		.clk     (clk),
		.rstN    (rstN),
		.rdIdxA  (rdIdxA),
		.rdIdxB  (rdIdxB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wb      (wbBus)
	);

	instrDecoder u_instrDecoder (
		.instr      (instr),
		.instrPc    (instrPc),
		.instrValid (instrValid),
		.rdIdxA     (rdIdxA),
		.rdIdxB     (rdIdxB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.decBundle  (decBundle)
	);

	hazardCtrl u_hazardCtrl (
		.clk         (clk),
		.rstN        (rstN),
		.decBundle   (decBundle),
		.exBundle    (exBundle),
		.takenBranch (takenBranch),
		.stall       (stall),
		.flush       (flush),
		.halted      (halted)
	);

	pipeDe u_pipeDe (
		.clk       (clk),
		.rstN      (rstN),
		.stall     (stall),
		.flush     (flush),
		.decBundle (decBundle),
		.exBundle  (exBundle)
	);

	execUnit u_execUnit (
		.clk          (clk),
		.rstN         (rstN),
		.exBundle     (exBundle),
		.takenBranch  (takenBranch),
		.branchTarget (branchTarget),
		.wbBus        (wbBus)
	);

	assign redirect = takenBranch;
	assign redirectPc = branchTarget;
	assign wbValid = wbBus.valid;
	assign wbReg = wbBus.regIdx;
	assign wbData = wbBus.data;

endmodule

//--- sim/tbProgramTable.svh
// Expected writes hold only for this exact program, with all registers starting at zero
`ifndef TB_PROGRAM_TABLE_SVH
`define TB_PROGRAM_TABLE_SVH

	localparam int progLen = 17;
	localparam int wbLen = 10;
	localparam isaPkg::wordT expTarget = 16'd11;	// BEQZ at 8 jumps to 8 + 1 + 2
	localparam logic [progLen-1:0] stallRows = 17'h02114;	// Rows 2, 4, 8 and 13 read the row ahead

	isaPkg::wordT progMem [progLen];
	pipePkg::wbT expWb [wbLen];

	task automatic loadTables();
		progMem[0] = 16'h5205;	// ADDI r1, r0, 5
		progMem[1] = 16'h543d;	// ADDI r2, r0, -3
		progMem[2] = 16'h1650;	// ADD r3, r1, r2 stalls on r2
		progMem[3] = 16'h2850;	// SUB r4, r1, r2 reads r2 through the register file
		progMem[4] = 16'h3aa0;	// AND r5, r2, r4 stalls on r4
		progMem[5] = 16'h4c50;	// XOR r6, r1, r2
		progMem[6] = 16'h6e88;	// SLT r7, r2, r1
		progMem[7] = 16'h6e50;	// SLT r7, r1, r2
		progMem[8] = 16'h71c2;	// BEQZ r7, +2 stalls on r7 and is taken
		progMem[9] = 16'h5241;	// ADDI r1, r1, 1 is dropped
		progMem[10] = 16'h5481;	// ADDI r2, r2, 1 is never fetched
		progMem[11] = 16'h7045;	// BEQZ r1, +5 is not taken
		progMem[12] = 16'h527f;	// ADDI r1, r1, -1
		progMem[13] = 16'h1448;	// ADD r2, r1, r1 stalls on r1
		progMem[14] = 16'hf000;	// HALT
		progMem[15] = 16'h5607;	// ADDI r3, r0, 7
		progMem[16] = 16'h5809;	// ADDI r4, r0, 9

		// Valid, register and data of each write in program order
		expWb[0] = {1'b1, 3'd1, 16'h0005};
		expWb[1] = {1'b1, 3'd2, 16'hfffd};
		expWb[2] = {1'b1, 3'd3, 16'h0002};
		expWb[3] = {1'b1, 3'd4, 16'h0008};	// 5 minus -3
		expWb[4] = {1'b1, 3'd5, 16'h0008};
		expWb[5] = {1'b1, 3'd6, 16'hfff8};
		expWb[6] = {1'b1, 3'd7, 16'h0001};	// -3 is less than 5
		expWb[7] = {1'b1, 3'd7, 16'h0000};
		expWb[8] = {1'b1, 3'd1, 16'h0004};
		expWb[9] = {1'b1, 3'd2, 16'h0008};
	endtask

`endif

//--- sim/tbDecodeExec.sv
// Runs the table program once with random fetch gaps; the program must end in HALT
module tbDecodeExec;

	logic clk;
	logic rstN;
	logic instrValid;
	isaPkg::wordT instr;
	isaPkg::wordT instrPc;
	logic stall;
	logic redirect;
	logic wbValid;
	logic halted;
	isaPkg::wordT redirectPc;
	isaPkg::wordT wbData;
	isaPkg::regIdxT wbReg;
	int redirectCount;

	`include "tbProgramTable.svh"

	decodeExecCore u_decodeExecCore (.*);

	task automatic stopRun(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic checkEqual(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			stopRun($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch model
	//////////////////////////////////////////////////////////////////////

	initial begin
		isaPkg::wordT pc;
		logic hold;
		int unsigned seed;
		int inExPc;
		logic expStall;
		seed = 32'he8d8_a1df;
		void'($urandom(seed));
		pc = '0;
		hold = 1'b0;
		inExPc = -1;	// Row loaded into execute at the last edge, -1 for a bubble
		instrValid = 1'b0;
		instr = '0;
		instrPc = '0;
		forever begin
			@(negedge clk);	// Stall and redirect are settled here
			hold = instrValid && stall;
			if (rstN) begin
				// Only a row right behind its producer has to wait
				expStall = instrValid && stallRows[pc] && (inExPc + 1 == int'(pc));
				checkEqual("stall", 16'(stall), 16'(expStall));
			end
			if (redirect) begin
				checkEqual("redirectPc", redirectPc, expTarget);
				redirectCount++;
				pc = redirectPc;	// The word in decode this cycle was dropped
				inExPc = -1;
			end else if (rstN && instrValid && !stall) begin
				inExPc = pc;
				pc++;
			end else begin
				inExPc = -1;
			end
			@(posedge clk);
			#1;
			if (!hold) begin
				instrValid = (pc < progLen) && ($urandom % 4 != 0);
				instr = instrValid ? progMem[pc] : '0;
				instrPc = pc;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reset, writeback monitor and end of run
	//////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		rstN = 1'b0;
		redirectCount = 0;
		loadTables();
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;
		for (int i = 0; i < wbLen; i++) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
			end while (!wbValid && cycles < 60);
			if (!wbValid) begin
				stopRun($sformatf("Timed out waiting for register write number %0d", i));
			end
			checkEqual("wbReg", 16'(wbReg), 16'(expWb[i].regIdx));
			checkEqual("wbData", wbData, expWb[i].data);
		end
		cycles = 0;
		while (!halted) begin
			if (cycles == 60) begin
				stopRun("Timed out waiting for halted to rise");
			end
			@(negedge clk);
			cycles++;
			if (wbValid) begin
				stopRun("A register write came after the last expected one");
			end
		end
		// Fetch may still offer the words behind HALT and none of them may act
		repeat (10) begin
			@(negedge clk);
			if (wbValid || redirect) begin
				stopRun("The slice kept writing or branching after halted rose");
			end
		end
		checkEqual("redirect count", 16'(redirectCount), 16'd1);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+sim
src/isaPkg.sv
src/pipePkg.sv
src/regFile.sv
src/instrDecoder.sv
src/hazardCtrl.sv
src/pipeDe.sv
src/execUnit.sv
src/decodeExecCore.sv
sim/tbDecodeExec.sv
